// File: source/cpu_pkg.sv
// Shared widths, instruction encoding and stage structs; imported by every pipeline module
package cpu_pkg;

    localparam int NUM_REGS = 64;

    typedef logic [63:0] word_t;
    typedef logic [63:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [5:0]  reg_num_t;
    typedef logic [2:0]  unit_t;
    typedef logic [1:0]  alu_op_t;

    // Execution units; any other code decodes to a nop
    localparam unit_t UNIT_NOP = 3'd0;
    localparam unit_t UNIT_ALU = 3'd1;

    localparam alu_op_t OP_ADD = 2'd0;
    localparam alu_op_t OP_SUB = 2'd1;
    localparam alu_op_t OP_AND = 2'd2;
    localparam alu_op_t OP_XOR = 2'd3;

    // Bit positions of the 32-bit instruction fields
    localparam int IMM_FLAG_BIT = 31;
    localparam int UNIT_HI      = 30;
    localparam int UNIT_LO      = 28;
    localparam int OP_HI        = 27;
    localparam int OP_LO        = 26;
    localparam int RD_HI        = 25;
    localparam int RD_LO        = 20;
    localparam int RS1_HI       = 19;
    localparam int RS1_LO       = 14;
    localparam int RS2_HI       = 13;
    localparam int RS2_LO       = 8;
    localparam int IMM_HI       = 13;
    localparam int IMM_LO       = 0;

    // One decoded instruction as it leaves decode
    typedef struct packed {
        logic     imm_flag;
        unit_t    unit;
        alu_op_t  op;
        reg_num_t rd;
        reg_num_t rs1;
        reg_num_t rs2;
        word_t    imm;
    } decoded_t;

    // Destination register and value from an ALU or commit
    typedef struct packed {
        reg_num_t rn;
        word_t    data;
    } result_t;

endpackage

// File: source/fetch.sv
// Instruction fetch: requests 64-bit words from instruction memory and presents 32-bit halves
module fetch
    import cpu_pkg::*;
#(
    parameter addr_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rst_n,
    output addr_t imem_addr,
    output logic  imem_addr_valid,
    input  word_t imem_data,
    input  logic  imem_data_valid,
    output inst_t inst,
    output logic  inst_valid,
    input  logic  advance
);

    typedef enum logic [1:0] {
        REQUEST,
        WAIT_DATA,
        LOW_HALF,
        HIGH_HALF
    } fetch_state_t;

    fetch_state_t state;
    addr_t        pc;
    word_t        word_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= REQUEST;
            pc    <= RESET_PC;
        end else begin
            case (state)
                // Idle cycle keeps the request line low between words
                REQUEST: begin
                    state <= WAIT_DATA;
                end
                WAIT_DATA: begin
                    if (imem_data_valid) begin
                        state <= LOW_HALF;
                    end
                end
                LOW_HALF: begin
                    if (advance) begin
                        state <= HIGH_HALF;
                    end
                end
                HIGH_HALF: begin
                    if (advance) begin
                        state <= REQUEST;
                        pc    <= pc + addr_t'(8);
                    end
                end
                default: begin
                    state <= REQUEST;
                end
            endcase
        end
    end

    // Word captured on the data strobe
    always_ff @(posedge clk) begin
        if (state == WAIT_DATA && imem_data_valid) begin
            word_q <= imem_data;
        end
    end

    assign imem_addr       = pc;
    assign imem_addr_valid = (state == WAIT_DATA);

    // Low half goes out first
    assign inst_valid = (state == LOW_HALF) || (state == HIGH_HALF);
    assign inst       = (state == HIGH_HALF) ? word_q[63:32] : word_q[31:0];

endmodule

// File: source/decode.sv
// Decode stage: holds one instruction and splits it into fields for the scheduler and regfile
module decode
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  inst_t    inst,
    input  logic     inst_valid,
    output logic     advance,
    input  logic     stall,
    output decoded_t dec,
    output logic     dec_valid
);

    inst_t inst_q;
    unit_t unit_raw;

    // Take a new instruction only when the scheduler is not holding us
    assign advance = inst_valid && !stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (!stall) begin
            dec_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            inst_q <= inst;
        end
    end

    assign unit_raw = inst_q[UNIT_HI:UNIT_LO];

    always_comb begin
        dec.imm_flag = inst_q[IMM_FLAG_BIT];
        // Only the ALU exists, everything else retires as a nop
        dec.unit     = (unit_raw == UNIT_ALU) ? UNIT_ALU : UNIT_NOP;
        dec.op       = inst_q[OP_HI:OP_LO];
        dec.rd       = inst_q[RD_HI:RD_LO];
        dec.rs1      = inst_q[RS1_HI:RS1_LO];
        dec.rs2      = inst_q[RS2_HI:RS2_LO];
        // Immediate is zero extended
        dec.imm      = word_t'(inst_q[IMM_HI:IMM_LO]);
    end

endmodule

// File: source/regfile.sv
// Register file: 64 entries, two combinational read ports and one write port with bypass
module regfile
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_num_t r1_rn,
    input  reg_num_t r2_rn,
    output word_t    r1_data,
    output word_t    r2_data,
    input  result_t  wb
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.rn != '0) begin
            regs[wb.rn] <= wb.data;
        end
    end

    // Register 0 reads zero, a register being written returns the new value
    assign r1_data = (r1_rn == '0)    ? '0      :
                     (r1_rn == wb.rn) ? wb.data : regs[r1_rn];
    assign r2_data = (r2_rn == '0)    ? '0      :
                     (r2_rn == wb.rn) ? wb.data : regs[r2_rn];

endmodule

// File: source/schedule.sv
// Scheduler: scoreboard of pending destinations, hazard stall and issue to a free ALU
module schedule
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  decoded_t dec,
    input  logic     dec_valid,
    output logic     stall,
    input  reg_num_t wb_rn,
    input  logic     alu1_busy,
    input  logic     alu2_busy,
    output logic     alu1_en,
    output logic     alu2_en,
    output decoded_t issue
);

    logic [NUM_REGS-1:0] pending;
    logic [NUM_REGS-1:0] pending_now;
    logic [NUM_REGS-1:0] clear_mask;
    logic [NUM_REGS-1:0] set_mask;
    logic                is_alu;
    logic                hazard;
    logic                both_busy;
    logic                alu_issue;

    // Writeback frees its register in the same cycle
    always_comb begin
        clear_mask = '0;
        if (wb_rn != '0) begin
            clear_mask[wb_rn] = 1'b1;
        end
    end

    assign pending_now = pending & ~clear_mask;

    assign is_alu = (dec.unit == UNIT_ALU);

    // rs2 only matters for the register form
    always_comb begin
        hazard = pending_now[dec.rs1] || pending_now[dec.rd] ||
                 (!dec.imm_flag && pending_now[dec.rs2]);
    end

    assign both_busy = alu1_busy && alu2_busy;
    assign alu_issue = dec_valid && is_alu && !hazard && !both_busy;

    // alu1 preferred when free
    assign alu1_en = alu_issue && !alu1_busy;
    assign alu2_en = alu_issue && alu1_busy;

    // Nops never stall and retire here
    assign stall = dec_valid && is_alu && (hazard || both_busy);

    // The decode register already holds the issued instruction
    assign issue = dec;

    always_comb begin
        set_mask = '0;
        if (alu_issue && dec.rd != '0) begin
            set_mask[dec.rd] = 1'b1;
        end
    end

    // Set wins over clear: a WAW issue only happens once the old write lands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= pending_now | set_mask;
        end
    end

endmodule

// File: source/ex_alu.sv
// Single-cycle ALU: computes on enable and holds its result until commit accepts it
module ex_alu
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,
    input  decoded_t issue,
    input  word_t    in1,
    input  word_t    in2,
    output logic     busy,
    output result_t  res,
    output logic     valid,
    input  logic     stall
);

    word_t operand2;
    word_t alu_out;

    assign operand2 = issue.imm_flag ? issue.imm : in2;

    always_comb begin
        case (issue.op)
            OP_ADD:  alu_out = in1 + operand2;
            OP_SUB:  alu_out = in1 - operand2;
            OP_AND:  alu_out = in1 & operand2;
            OP_XOR:  alu_out = in1 ^ operand2;
            default: alu_out = '0;
        endcase
    end

    // Valid drops only once commit has taken the result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (en) begin
            valid <= 1'b1;
        end else if (!stall) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            res.rn   <= issue.rd;
            res.data <= alu_out;
        end
    end

    // Not eligible for issue while a result is held
    assign busy = valid;

endmodule

// File: source/commit.sv
// Commit: fixed-priority arbiter between the ALUs with a registered write-back port
module commit
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  result_t alu1_res,
    input  result_t alu2_res,
    input  logic    alu1_valid,
    input  logic    alu2_valid,
    output logic    alu1_stall,
    output logic    alu2_stall,
    output result_t wb
);

    // alu1 always wins, so only alu2 ever waits
    assign alu1_stall = 1'b0;
    assign alu2_stall = alu1_valid && alu2_valid;

    // rn of zero means no write this cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else if (alu1_valid) begin
            wb <= alu1_res;
        end else if (alu2_valid) begin
            wb <= alu2_res;
        end else begin
            wb <= '0;
        end
    end

endmodule

// File: source/pipeline.sv
// Pipeline top level: connects fetch, decode, regfile, scheduler, two ALUs and commit
module pipeline
    import cpu_pkg::*;
#(
    parameter addr_t RESET_PC = '0
) (
    input  logic     clk,
    input  logic     rst_n,
    output addr_t    imem_addr,
    output logic     imem_addr_valid,
    input  word_t    imem_data,
    input  logic     imem_data_valid,
    output reg_num_t commit_rn,
    output word_t    commit_data
);

    // Fetch to decode
    inst_t    fe_inst;
    logic     fe_inst_valid;
    logic     de_advance;

    // Decode to schedule and regfile
    decoded_t de_dec;
    logic     de_dec_valid;
    logic     sc_stall;

    word_t    rf_data1;
    word_t    rf_data2;

    // Schedule to execute
    decoded_t sc_issue;
    logic     sc_alu1_en;
    logic     sc_alu2_en;
    logic     ex_alu1_busy;
    logic     ex_alu2_busy;

    // Execute to commit
    result_t  ex_alu1_res;
    result_t  ex_alu2_res;
    logic     ex_alu1_valid;
    logic     ex_alu2_valid;
    logic     cm_alu1_stall;
    logic     cm_alu2_stall;
    result_t  cm_wb;

    fetch #(
        .RESET_PC(RESET_PC)
    ) i_fetch (
        .clk(clk), .rst_n(rst_n),
        .imem_addr(imem_addr), .imem_addr_valid(imem_addr_valid),
        .imem_data(imem_data), .imem_data_valid(imem_data_valid),
        .inst(fe_inst), .inst_valid(fe_inst_valid), .advance(de_advance)
    );

    decode i_decode (
        .clk(clk), .rst_n(rst_n),
        .inst(fe_inst), .inst_valid(fe_inst_valid), .advance(de_advance),
        .stall(sc_stall), .dec(de_dec), .dec_valid(de_dec_valid)
    );

    // Read alongside scheduling, written by commit
    regfile i_regfile (
        .clk(clk), .rst_n(rst_n),
        .r1_rn(de_dec.rs1), .r2_rn(de_dec.rs2),
        .r1_data(rf_data1), .r2_data(rf_data2), .wb(cm_wb)
    );

    schedule i_schedule (
        .clk(clk), .rst_n(rst_n),
        .dec(de_dec), .dec_valid(de_dec_valid), .stall(sc_stall),
        .wb_rn(cm_wb.rn),
        .alu1_busy(ex_alu1_busy), .alu2_busy(ex_alu2_busy),
        .alu1_en(sc_alu1_en), .alu2_en(sc_alu2_en), .issue(sc_issue)
    );

    ex_alu i_alu1 (
        .clk(clk), .rst_n(rst_n), .en(sc_alu1_en), .issue(sc_issue),
        .in1(rf_data1), .in2(rf_data2), .busy(ex_alu1_busy),
        .res(ex_alu1_res), .valid(ex_alu1_valid), .stall(cm_alu1_stall)
    );

    ex_alu i_alu2 (
        .clk(clk), .rst_n(rst_n), .en(sc_alu2_en), .issue(sc_issue),
        .in1(rf_data1), .in2(rf_data2), .busy(ex_alu2_busy),
        .res(ex_alu2_res), .valid(ex_alu2_valid), .stall(cm_alu2_stall)
    );

    commit i_commit (
        .clk(clk), .rst_n(rst_n),
        .alu1_res(ex_alu1_res), .alu2_res(ex_alu2_res),
        .alu1_valid(ex_alu1_valid), .alu2_valid(ex_alu2_valid),
        .alu1_stall(cm_alu1_stall), .alu2_stall(cm_alu2_stall),
        .wb(cm_wb)
    );

    assign commit_rn   = cm_wb.rn;
    assign commit_data = cm_wb.data;

endmodule

// File: tb/pipeline_assertions.sv
// Concurrent checks on pipeline internals, bound into every pipeline instance below
module pipeline_assertions
    import cpu_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input addr_t   imem_addr,
    input logic    imem_addr_valid,
    input logic    imem_data_valid,
    input logic    alu1_en,
    input logic    alu2_en,
    input result_t alu2_res,
    input logic    alu2_valid,
    input logic    alu2_stall
);
    timeunit 1ns;
    timeprecision 1ps;

    // Read by the testbench at the end of the run
    int unsigned failures = 0;

    // At most one ALU gets an instruction per cycle
    single_issue: assert property (@(posedge clk) disable iff (!rst_n)
        !(alu1_en && alu2_en))
    else begin
        failures++;
        $error("Both ALU enables high in the same cycle");
    end

    // Only alu2 can be held back by commit
    alu2_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (alu2_valid && alu2_stall) |=> (alu2_valid && alu2_res == $past(alu2_res)))
    else begin
        failures++;
        $error("ALU2 result changed while stalled");
    end

    // Request stays put until its data strobe
    addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (imem_addr_valid && !imem_data_valid) |=> (imem_addr_valid && $stable(imem_addr)))
    else begin
        failures++;
        $error("Instruction memory request dropped or moved before its data");
    end

endmodule

bind pipeline pipeline_assertions i_assertions (
    .clk(clk), .rst_n(rst_n),
    .imem_addr(imem_addr), .imem_addr_valid(imem_addr_valid),
    .imem_data_valid(imem_data_valid),
    .alu1_en(sc_alu1_en), .alu2_en(sc_alu2_en),
    .alu2_res(ex_alu2_res), .alu2_valid(ex_alu2_valid), .alu2_stall(cm_alu2_stall)
);

// File: tb/tb_pipeline.sv
// Testbench for the pipeline: random program from a variable-latency memory, checked in order
module tb_pipeline
    import cpu_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam addr_t RESET_PC       = 64'h1000;
    localparam int    PROG_INSTS     = 200;
    localparam int    PROG_WORDS     = PROG_INSTS / 2;
    localparam int    COMMIT_TIMEOUT = 20000;
    localparam int    DRAIN_CYCLES   = 60;

    // Expected write and the form of the instruction behind it
    typedef struct packed {
        logic  imm_form;
        word_t value;
    } expect_t;

    logic     clk;
    logic     rst_n;
    addr_t    imem_addr;
    logic     imem_addr_valid;
    word_t    imem_data;
    logic     imem_data_valid;
    reg_num_t commit_rn;
    word_t    commit_data;

    logic [31:0] lfsr = 32'hff6f;
    word_t       prog_mem [PROG_WORDS];
    expect_t     exp_q [NUM_REGS][$];
    addr_t       next_addr = RESET_PC;
    int          commit_count = 0;
    int          expected_commits = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errs [1:7] = '{default: 0};
    string       test_names [1:7] = '{"reset state", "fetch addresses", "register-form results",
                                      "immediate-form results", "commit count",
                                      "per-register queues drained", "bound assertions"};

    pipeline #(
        .RESET_PC(RESET_PC)
    ) i_dut (
        .clk(clk), .rst_n(rst_n),
        .imem_addr(imem_addr), .imem_addr_valid(imem_addr_valid),
        .imem_data(imem_data), .imem_data_valid(imem_data_valid),
        .commit_rn(commit_rn), .commit_data(commit_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return bits;
    endfunction

    // Random program and the in-order model of its register writes
    task automatic build_program();
        word_t       regs [NUM_REGS];
        inst_t       ins;
        unit_t       unit;
        alu_op_t     op;
        reg_num_t    rd;
        reg_num_t    rs1;
        reg_num_t    rs2;
        logic        imm_flag;
        logic [13:0] imm;
        word_t       op2;
        word_t       result;
        for (int r = 0; r < NUM_REGS; r++) begin
            regs[r] = '0;
        end
        for (int n = 0; n < PROG_INSTS; n++) begin
            imm_flag = 1'(take_bits(1));
            // Codes 6 and 7 stay as non-ALU nops
            unit = unit_t'(take_bits(3));
            if (unit < 3'd6) begin
                unit = UNIT_ALU;
            end
            op  = alu_op_t'(take_bits(2));
            rd  = reg_num_t'(take_bits(3));
            rs1 = reg_num_t'(take_bits(3));
            rs2 = reg_num_t'(take_bits(3));
            imm = imm_flag ? 14'(take_bits(14)) : {rs2, 8'h00};
            ins = '0;
            ins[IMM_FLAG_BIT]    = imm_flag;
            ins[UNIT_HI:UNIT_LO] = unit;
            ins[OP_HI:OP_LO]     = op;
            ins[RD_HI:RD_LO]     = rd;
            ins[RS1_HI:RS1_LO]   = rs1;
            ins[IMM_HI:IMM_LO]   = imm;
            if (unit == UNIT_ALU) begin
                op2 = imm_flag ? word_t'(imm) : regs[rs2];
                case (op)
                    OP_ADD:  result = regs[rs1] + op2;
                    OP_SUB:  result = regs[rs1] - op2;
                    OP_AND:  result = regs[rs1] & op2;
                    default: result = regs[rs1] ^ op2;
                endcase
                // Register 0 is never written and never commits
                if (rd != '0) begin
                    regs[rd] = result;
                    exp_q[rd].push_back(expect_t'{imm_flag, result});
                    expected_commits++;
                end
            end
            if (n % 2 == 0) begin
                prog_mem[n / 2][31:0] = ins;
            end else begin
                prog_mem[n / 2][63:32] = ins;
            end
        end
    endtask

    // Past the program the memory reads zero, which decodes to nops
    function automatic word_t read_word(addr_t addr);
        addr_t idx;
        idx = (addr - RESET_PC) >> 3;
        return (idx < addr_t'(PROG_WORDS)) ? prog_mem[int'(idx)] : '0;
    endfunction

    // Answers each request after 1 to 4 cycles
    initial begin : memory_model
        int    wait_left;
        addr_t req_addr;
        wait_left       = 0;
        req_addr        = '0;
        imem_data       = '0;
        imem_data_valid = 1'b0;
        forever begin
            @(posedge clk);
            imem_data_valid <= 1'b0;
            if (wait_left > 0) begin
                wait_left--;
                if (wait_left == 0) begin
                    imem_data       <= read_word(req_addr);
                    imem_data_valid <= 1'b1;
                end
            end else if (imem_addr_valid && !imem_data_valid) begin
                req_addr = imem_addr;
                assert (req_addr == next_addr) else begin
                    $display("Fail imem_addr: got %h expected %h", req_addr, next_addr);
                    errs[2]++;
                end
                next_addr = next_addr + addr_t'(8);
                wait_left = 1 + int'(take_bits(2));
            end
        end
    end

    task automatic check_commit(reg_num_t rn, word_t data);
        expect_t exp;
        commit_count++;
        if (exp_q[rn].size() == 0) begin
            $display("Commit to register %0d with no write left for it in the program", rn);
            errs[5]++;
        end else begin
            exp = exp_q[rn].pop_front();
            assert (data == exp.value) else begin
                $display("Fail commit_data: got %h expected %h (register %0d)",
                         data, exp.value, rn);
                errs[exp.imm_form ? 4 : 3]++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && commit_rn != '0) begin
            check_commit(commit_rn, commit_data);
        end
    end

    task automatic check_reset_state();
        assert (!imem_addr_valid) else begin
            $display("Fail imem_addr_valid: got %h expected %h", imem_addr_valid, 1'b0);
            errs[1]++;
        end
        assert (commit_rn == '0) else begin
            $display("Fail commit_rn: got %h expected %h", commit_rn, 6'h0);
            errs[1]++;
        end
        assert (imem_addr == RESET_PC) else begin
            $display("Fail imem_addr: got %h expected %h", imem_addr, RESET_PC);
            errs[1]++;
        end
    endtask

    task automatic report_test(int t);
        tests_run++;
        if (errs[t] == 0) begin
            $display("[pass] %s", test_names[t]);
        end else begin
            tests_failed++;
            $display("[fail] %s, %0d errors", test_names[t], errs[t]);
        end
    endtask

    initial begin : main
        int cycles;
        rst_n = 1'b0;
        build_program();
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_reset_state();
        @(posedge clk);
        rst_n <= 1'b1;
        // First cycle out of reset
        @(negedge clk);
        check_reset_state();
        report_test(1);
        cycles = 0;
        while (commit_count < expected_commits && cycles < COMMIT_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (commit_count < expected_commits) begin
            $display("Timed out after %0d cycles waiting for the remaining commits", cycles);
            errs[5]++;
        end
        // Late or extra commits show up during the drain
        for (int c = 0; c < DRAIN_CYCLES; c++) begin
            @(posedge clk);
        end
        assert (commit_count == expected_commits) else begin
            $display("Fail commit count: got %h expected %h", commit_count, expected_commits);
            errs[5]++;
        end
        for (int r = 0; r < NUM_REGS; r++) begin
            assert (exp_q[r].size() == 0) else begin
                $display("Register %0d still has %0d expected writes that never committed",
                         r, exp_q[r].size());
                errs[6]++;
            end
        end
        errs[7] = int'(i_dut.i_assertions.failures);
        for (int t = 2; t <= 7; t++) begin
            report_test(t);
        end
        $display("%0d tests: %0d passed, %0d failed",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
source/cpu_pkg.sv
source/fetch.sv
source/decode.sv
source/regfile.sv
source/schedule.sv
source/ex_alu.sv
source/commit.sv
source/pipeline.sv
tb/pipeline_assertions.sv
tb/tb_pipeline.sv
